// ==== icache_refill.f ====
common/refill_pkg.sv
common/fill_if.sv
source/fetch_miss_ctrl.sv
fill_buffer/fill_buffer.sv
source/line_store.sv
source/icache_refill_top.sv
verif/fill_buffer_assert.sv
verif/icache_refill_tb.sv

// ==== Makefile ====
TOP := icache_refill_tb
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f icache_refill.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== verif/icache_refill_tb.sv ====
// Lockstep model testbench; assumes INDEX_WIDTH 3 and a pool of twelve lines in sets 3 and 5.
module icache_refill_tb;
    import refill_pkg::*;

    localparam int NUM_FETCH = 400;
    localparam int SLOTS = 12;
    localparam int TIMEOUT_CYCLES = 40 * NUM_FETCH + 100;

    logic  core_clk;
    logic  core_reset_n;
    logic  fetch_req;
    pa_t   fetch_pa;
    logic  fetch_hit;
    logic  fetch_wait;
    logic  fetch_error;
    word_t fetch_data;
    logic  bus_req_valid;
    pa_t   bus_req_pa;
    logic  bus_req_ready;
    logic  bus_wr;
    beat_t bus_wr_data;
    logic  bus_wr_error;

    word_t line_mem [SLOTS][8];
    int    m_slot [8][4];
    bit    m_valid [8][4];
    int    m_rr [8];
    int    b_state;  // 0 idle, 1 request, 2 collect, 3 first fill, 4 last fill.
    int    b_slot, b_way, b_idx;
    bit    b_got [2];
    bit    b_err [2];
    bit    err_plan [2];
    int    req_delay, beat_gap, wr_beat;
    int    slot, word, idx, r;
    bit    s_hit, b_hit, b_wait;
    int    n_fetch, errors;
    int    cov_store, cov_buf, cov_wait, cov_err, cov_evict;

    icache_refill_top #(.INDEX_WIDTH(3)) dut (
        .core_clk, .core_reset_n, .fetch_req, .fetch_pa,
        .fetch_hit, .fetch_wait, .fetch_error, .fetch_data,
        .bus_req_valid, .bus_req_pa, .bus_req_ready,
        .bus_wr, .bus_wr_data, .bus_wr_error
    );

    bind fill_buffer fill_buffer_assert u_fill_buffer_assert (
        .core_clk, .core_reset_n, .bus_req_valid, .bus_req_pa, .bus_req_ready,
        .bus_wr, .buf_available,
        .fill_valid (fill.fill_valid),
        .fill_last  (fill.fill_last)
    );

    function automatic pa_t line_pa(input int s);
        logic [22:0] tag;
        logic [2:0]  set;
        tag = 23'h2a_1000 + 23'(s * 'h1c3);
        set = (s < 6) ? 3'd3 : 3'd5;
        return {tag, set, 6'b0};
    endfunction

    function automatic beat_t beat_of(input int s, input int beat);
        beat_t b;
        for (int i = 0; i < 4; i++) begin
            b[64*i +: 64] = line_mem[s][4*beat + i];
        end
        return b;
    endfunction

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic init_model();
        pa_t pa;
        for (int s = 0; s < SLOTS; s++) begin
            for (int w = 0; w < 8; w++) begin
                pa = line_pa(s) | pa_t'(w << 3);
                line_mem[s][w] = {pa ^ 32'h3c5a_96e1, ~pa};  // Unique per word address.
            end
        end
    endtask

    // The responder follows the model state, which the bus_req_valid check keeps honest.
    task automatic drive_bus();
        bus_req_ready = 1'b0;
        bus_wr        = 1'b0;
        bus_wr_error  = 1'b0;
        bus_wr_data   = '0;
        wr_beat       = -1;
        if (b_state == 1) begin
            if (req_delay == 0) bus_req_ready = 1'b1;
            else req_delay--;
        end else if (b_state == 2) begin
            if (beat_gap == 0) begin
                wr_beat      = b_got[0] ? 1 : 0;
                bus_wr       = 1'b1;
                bus_wr_error = err_plan[wr_beat];
                bus_wr_data  = beat_of(b_slot, wr_beat);
                beat_gap     = $urandom % 3;
            end else begin
                beat_gap--;
            end
        end
    endtask

    task automatic drive_fetch();
        fetch_req = (n_fetch < NUM_FETCH) && ($urandom % 4 != 0);
        slot      = $urandom % SLOTS;
        word      = $urandom % 8;
        fetch_pa  = line_pa(slot) | pa_t'(word << 3);
        if (fetch_req) n_fetch++;
    endtask

    task automatic check_outputs();
        idx   = int'(fetch_pa[8:6]);
        s_hit = 1'b0;
        for (int w = 0; w < 4; w++) begin
            if (m_valid[idx][w] && m_slot[idx][w] == slot) s_hit = 1'b1;
        end
        b_hit  = (b_state != 0) && (b_slot == slot) && b_got[word / 4];
        b_wait = (b_state != 0) && (b_slot == slot) && !b_got[word / 4];
        compare("fetch_hit", 64'(fetch_hit), 64'(fetch_req && (s_hit || b_hit)));
        compare("fetch_wait", 64'(fetch_wait), 64'(fetch_req && !s_hit && b_wait));
        compare("fetch_error", 64'(fetch_error),
                64'(fetch_req && !s_hit && b_hit && (b_err[0] || b_err[1])));
        if (fetch_req && (s_hit || b_hit)) compare("fetch_data", fetch_data, line_mem[slot][word]);
        compare("bus_req_valid", 64'(bus_req_valid), 64'(b_state == 1));
        if (b_state == 1) compare("bus_req_pa", 64'(bus_req_pa), 64'(line_pa(b_slot)));
        if (fetch_req && s_hit) cov_store++;
        if (fetch_req && !s_hit && b_hit) cov_buf++;
        if (fetch_req && !s_hit && b_wait) cov_wait++;
        if (fetch_req && !s_hit && b_hit && (b_err[0] || b_err[1])) cov_err++;
    endtask

    task automatic advance_model();
        case (b_state)
            1: if (bus_req_ready) b_state = 2;
            2: begin
                if (wr_beat >= 0) begin
                    b_got[wr_beat] = 1'b1;
                    b_err[wr_beat] = bus_wr_error;
                    if (wr_beat == 1) b_state = (b_err[0] || b_err[1]) ? 0 : 3;
                end
            end
            3: begin
                m_slot[b_idx][b_way]  = b_slot;
                m_valid[b_idx][b_way] = 1'b0;  // First half leaves the line invalid.
                b_state = 4;
            end
            4: begin
                m_valid[b_idx][b_way] = 1'b1;
                b_state = 0;
            end
            default: begin
                if (fetch_req && !s_hit) begin
                    b_slot = slot;
                    b_idx  = idx;
                    b_way  = m_rr[idx];
                    if (m_valid[idx][b_way]) cov_evict++;
                    m_rr[idx] = (m_rr[idx] + 1) % 4;
                    b_got     = '{1'b0, 1'b0};
                    b_err     = '{1'b0, 1'b0};
                    r         = $urandom % 16;  // One line in eight has an errored beat.
                    err_plan  = '{r == 0, r == 1};
                    req_delay = $urandom % 4;
                    beat_gap  = $urandom % 3;
                    b_state   = 1;
                end
            end
        endcase
    endtask

    initial begin
        core_clk = 1'b0;
        forever #10 core_clk = ~core_clk;
    end

    initial begin
        #(TIMEOUT_CYCLES * 20);
        $display("Watchdog expired before the fetch sequence completed.");
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        void'($urandom(32'h3652_2352));
        core_reset_n  = 1'b0;
        fetch_req     = 1'b0;
        fetch_pa      = '0;
        bus_req_ready = 1'b0;
        bus_wr        = 1'b0;
        bus_wr_data   = '0;
        bus_wr_error  = 1'b0;
        init_model();
        repeat (8) @(negedge core_clk);
        core_reset_n = 1'b1;
        #5;
        compare("bus_req_valid", 64'(bus_req_valid), 64'(0));
        compare("fetch_hit", 64'(fetch_hit), 64'(0));
        compare("fetch_wait", 64'(fetch_wait), 64'(0));
        compare("fetch_error", 64'(fetch_error), 64'(0));
        while (n_fetch < NUM_FETCH || b_state != 0) begin
            @(negedge core_clk);
            drive_bus();
            drive_fetch();
            #5;
            check_outputs();
            advance_model();
        end
        if (cov_store == 0 || cov_buf == 0 || cov_wait == 0 || cov_err == 0 || cov_evict == 0) begin
            errors++;
            $display("Stimulus missed a store hit, buffer hit, wait, error hit or eviction.");
        end
        $display("fetches %0d, store hits %0d, buffer hits %0d, waits %0d, evictions %0d, errors %0d",
                 n_fetch, cov_store, cov_buf, cov_wait, cov_evict, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== verif/fill_buffer_assert.sv ====
// Sees only fill buffer ports and the fill strobe; every check is off while reset is low.
module fill_buffer_assert (
    input logic            core_clk,
    input logic            core_reset_n,
    input logic            bus_req_valid,
    input refill_pkg::pa_t bus_req_pa,
    input logic            bus_req_ready,
    input logic            bus_wr,
    input logic            buf_available,
    input logic            fill_valid,
    input logic            fill_last
);

    req_pa_stable: assert property (@(posedge core_clk) disable iff (!core_reset_n)
        bus_req_valid && !bus_req_ready |=> bus_req_valid && $stable(bus_req_pa))
        else $error("bus request dropped or its address changed before ready");

    no_fill_during_req: assert property (@(posedge core_clk) disable iff (!core_reset_n)
        !(fill_valid && bus_req_valid))
        else $error("fill strobe while a bus request is pending");

    last_after_first: assert property (@(posedge core_clk) disable iff (!core_reset_n)
        fill_last |-> $past(fill_valid && !fill_last))
        else $error("last fill strobe without a first strobe in the cycle before");

    no_beat_when_idle: assert property (@(posedge core_clk) disable iff (!core_reset_n)
        bus_wr |-> !buf_available)
        else $error("bus beat arrived while the fill buffer was idle");

endmodule

// ==== source/icache_refill_top.sv ====
// Refill path top; assumes one outstanding miss, and the fetcher retries misses that are dropped.
module icache_refill_top #(
    parameter int INDEX_WIDTH = 3
) (
    input  logic               core_clk,
    input  logic               core_reset_n,
    input  logic               fetch_req,
    input  refill_pkg::pa_t    fetch_pa,
    output logic               fetch_hit,
    output logic               fetch_wait,
    output logic               fetch_error,
    output refill_pkg::word_t  fetch_data,
    output logic               bus_req_valid,
    output refill_pkg::pa_t    bus_req_pa,
    input  logic               bus_req_ready,
    input  logic               bus_wr,
    input  refill_pkg::beat_t  bus_wr_data,
    input  logic               bus_wr_error
);
    import refill_pkg::*;

    logic  store_hit;
    word_t store_data;
    logic  buf_available;
    logic  buf_hit;
    logic  buf_wait;
    logic  buf_error;
    word_t buf_data;
    logic  alloc;
    pa_t   alloc_pa;
    way_t  alloc_way;

    fill_if #(.INDEX_WIDTH(INDEX_WIDTH)) fill ();

    fetch_miss_ctrl #(.INDEX_WIDTH(INDEX_WIDTH)) u_fetch_miss_ctrl (
        .core_clk, .core_reset_n, .fetch_req, .fetch_pa,
        .store_hit, .store_data,
        .buf_available, .buf_hit, .buf_wait, .buf_error, .buf_data,
        .fetch_hit, .fetch_wait, .fetch_error, .fetch_data,
        .alloc, .alloc_pa, .alloc_way
    );

    fill_buffer #(.INDEX_WIDTH(INDEX_WIDTH)) u_fill_buffer (
        .core_clk, .core_reset_n, .alloc, .alloc_pa, .alloc_way, .fetch_pa,
        .bus_req_valid, .bus_req_pa, .bus_req_ready,
        .bus_wr, .bus_wr_data, .bus_wr_error,
        .buf_available, .buf_hit, .buf_wait, .buf_error, .buf_data,
        .fill   (fill.source)
    );

    line_store #(.INDEX_WIDTH(INDEX_WIDTH)) u_line_store (
        .core_clk, .core_reset_n, .fetch_pa,
        .fill   (fill.sink),
        .store_hit, .store_data
    );

endmodule

// ==== source/line_store.sv ====
// Four-way store built from registers; a fill is always accepted and a line hits only once complete.
module line_store #(
    parameter int INDEX_WIDTH = 3
) (
    input  logic               core_clk,
    input  logic               core_reset_n,
    input  refill_pkg::pa_t    fetch_pa,
    fill_if.sink               fill,
    output logic               store_hit,
    output refill_pkg::word_t  store_data
);
    import refill_pkg::*;

    localparam int TAG_WIDTH = 32 - LINE_OFFSET_BITS - INDEX_WIDTH;
    localparam int SETS = 2 ** INDEX_WIDTH;

    logic [TAG_WIDTH-1:0]   tag_q   [SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0]    valid_q [SETS];
    word_t                  data_q  [SETS][NUM_WAYS][8];
    logic [INDEX_WIDTH-1:0] fetch_index;
    logic [TAG_WIDTH-1:0]   fetch_tag;
    word_sel_t              fetch_sel;
    logic [NUM_WAYS-1:0]    way_hit;
    way_t                   hit_way;

    assign fetch_index = fetch_pa[LINE_OFFSET_BITS +: INDEX_WIDTH];
    assign fetch_tag   = fetch_pa[31 -: TAG_WIDTH];
    assign fetch_sel   = fetch_pa[LINE_OFFSET_BITS-1:3];

    // At most one way can match, since a line is only allocated after a miss.
    always_comb begin
        way_hit = '0;
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            way_hit[w] = valid_q[fetch_index][w] && (tag_q[fetch_index][w] == fetch_tag);
            if (way_hit[w]) begin
                hit_way = way_t'(w);
            end
        end
    end

    assign store_hit  = |way_hit;
    assign store_data = data_q[fetch_index][hit_way][fetch_sel];

    // The first half clears valid and the last half sets it.
    always_ff @(posedge core_clk or negedge core_reset_n) begin
        if (!core_reset_n) begin
            for (int s = 0; s < SETS; s++) begin
                valid_q[s] <= '0;
            end
        end else if (fill.fill_valid) begin
            valid_q[fill.fill_index][fill.fill_way] <= fill.fill_last;
        end
    end

    always_ff @(posedge core_clk) begin
        if (fill.fill_valid) begin
            if (!fill.fill_last) begin
                tag_q[fill.fill_index][fill.fill_way] <= fill.fill_tag;
            end
            for (int i = 0; i < 4; i++) begin
                data_q[fill.fill_index][fill.fill_way][{fill.fill_last, 2'(i)}] <=
                    fill.fill_data[i];
            end
        end
    end

endmodule

// ==== fill_buffer/fill_buffer.sv ====
// One line in flight; beat 0 must arrive before beat 1, and a line with any errored beat is not filled.
module fill_buffer #(
    parameter int INDEX_WIDTH = 3
) (
    input  logic               core_clk,
    input  logic               core_reset_n,
    input  logic               alloc,
    input  refill_pkg::pa_t    alloc_pa,
    input  refill_pkg::way_t   alloc_way,
    input  refill_pkg::pa_t    fetch_pa,
    output logic               bus_req_valid,
    output refill_pkg::pa_t    bus_req_pa,
    input  logic               bus_req_ready,
    input  logic               bus_wr,
    input  refill_pkg::beat_t  bus_wr_data,
    input  logic               bus_wr_error,
    output logic               buf_available,
    output logic               buf_hit,
    output logic               buf_wait,
    output logic               buf_error,
    output refill_pkg::word_t  buf_data,
    fill_if.source             fill
);
    import refill_pkg::*;

    localparam int LINE_ADDR_WIDTH = 32 - LINE_OFFSET_BITS;
    localparam int TAG_WIDTH = LINE_ADDR_WIDTH - INDEX_WIDTH;

    typedef enum logic [2:0] {
        st_idle,
        st_request,
        st_collect,
        st_fill_first,
        st_fill_last
    } state_t;

    state_t                     state_q;
    state_t                     state_d;
    logic [LINE_ADDR_WIDTH-1:0] line_q;
    way_t                       way_q;
    beat_t                      beat_q [2];
    logic [1:0]                 got_q;
    logic [1:0]                 err_q;
    logic                       beat_wr;
    logic                       beat_sel;
    logic                       last_beat;
    logic                       line_match;
    logic                       busy;
    word_sel_t                  fetch_sel;

    assign beat_wr   = bus_wr & (state_q == st_collect);
    assign beat_sel  = got_q[0];  // Beats arrive in order, so beat 1 follows a received beat 0.
    assign last_beat = beat_wr & got_q[0];

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: begin
                if (alloc) begin
                    state_d = st_request;
                end
            end
            st_request: begin
                if (bus_req_ready) begin
                    state_d = st_collect;
                end
            end
            st_collect: begin
                if (last_beat) begin
                    state_d = (err_q[0] | bus_wr_error) ? st_idle : st_fill_first;
                end
            end
            st_fill_first: state_d = st_fill_last;
            st_fill_last:  state_d = st_idle;
            default:       state_d = st_idle;
        endcase
    end

    always_ff @(posedge core_clk or negedge core_reset_n) begin
        if (!core_reset_n) begin
            state_q <= st_idle;
            got_q   <= '0;
            err_q   <= '0;
        end else begin
            state_q <= state_d;
            if (alloc) begin
                got_q <= '0;
                err_q <= '0;
            end else if (beat_wr) begin
                got_q[beat_sel] <= 1'b1;
                err_q[beat_sel] <= bus_wr_error;
            end
        end
    end

    always_ff @(posedge core_clk) begin
        if (alloc) begin
            line_q <= alloc_pa[31:LINE_OFFSET_BITS];
            way_q  <= alloc_way;
        end
        if (beat_wr) begin
            beat_q[beat_sel] <= bus_wr_data;
        end
    end

    assign bus_req_valid = (state_q == st_request);
    assign bus_req_pa    = {line_q, {LINE_OFFSET_BITS{1'b0}}};

    // Lookup against the line in flight.
    assign busy       = (state_q != st_idle);
    assign line_match = (fetch_pa[31:LINE_OFFSET_BITS] == line_q);
    assign fetch_sel  = fetch_pa[LINE_OFFSET_BITS-1:3];

    assign buf_available = ~busy;
    assign buf_hit       = busy & line_match & got_q[fetch_sel[2]];
    assign buf_wait      = busy & line_match & ~got_q[fetch_sel[2]];
    assign buf_error     = |err_q;
    assign buf_data      = beat_q[fetch_sel[2]][64*fetch_sel[1:0] +: 64];

    assign fill.fill_valid = (state_q == st_fill_first) | (state_q == st_fill_last);
    assign fill.fill_last  = (state_q == st_fill_last);
    assign fill.fill_way   = way_q;
    assign fill.fill_tag   = line_q[INDEX_WIDTH +: TAG_WIDTH];
    assign fill.fill_index = line_q[INDEX_WIDTH-1:0];

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            fill.fill_data[i] = beat_q[fill.fill_last][64*i +: 64];
        end
    end

endmodule

// ==== source/fetch_miss_ctrl.sv ====
// Misses that find the fill buffer busy are dropped; the fetcher must retry them.
module fetch_miss_ctrl #(
    parameter int INDEX_WIDTH = 3
) (
    input  logic               core_clk,
    input  logic               core_reset_n,
    input  logic               fetch_req,
    input  refill_pkg::pa_t    fetch_pa,
    input  logic               store_hit,
    input  refill_pkg::word_t  store_data,
    input  logic               buf_available,
    input  logic               buf_hit,
    input  logic               buf_wait,
    input  logic               buf_error,
    input  refill_pkg::word_t  buf_data,
    output logic               fetch_hit,
    output logic               fetch_wait,
    output logic               fetch_error,
    output refill_pkg::word_t  fetch_data,
    output logic               alloc,
    output refill_pkg::pa_t    alloc_pa,
    output refill_pkg::way_t   alloc_way
);
    import refill_pkg::*;

    localparam int SETS = 2 ** INDEX_WIDTH;

    logic [INDEX_WIDTH-1:0] fetch_index;
    way_t                   rr_q [SETS];

    assign fetch_index = fetch_pa[LINE_OFFSET_BITS +: INDEX_WIDTH];

    // The store wins over the buffer when both hold the word.
    assign fetch_hit   = fetch_req & (store_hit | buf_hit);
    assign fetch_wait  = fetch_req & ~store_hit & buf_wait;
    assign fetch_error = fetch_req & ~store_hit & buf_hit & buf_error;
    assign fetch_data  = store_hit ? store_data : buf_data;

    assign alloc     = fetch_req & ~store_hit & ~buf_hit & ~buf_wait & buf_available;
    assign alloc_pa  = fetch_pa;
    assign alloc_way = rr_q[fetch_index];

    // One round-robin victim pointer per set, advanced on every allocation.
    always_ff @(posedge core_clk or negedge core_reset_n) begin
        if (!core_reset_n) begin
            for (int s = 0; s < SETS; s++) begin
                rr_q[s] <= '0;
            end
        end else if (alloc) begin
            rr_q[fetch_index] <= rr_q[fetch_index] + 2'd1;
        end
    end

endmodule

// ==== common/fill_if.sv ====
// Half-line fill strobe; always accepted, two strobes in consecutive cycles, first then last.
interface fill_if #(
    parameter int INDEX_WIDTH = 3
);
    import refill_pkg::*;

    localparam int TAG_WIDTH = 32 - LINE_OFFSET_BITS - INDEX_WIDTH;

    logic                   fill_valid;
    way_t                   fill_way;
    logic [TAG_WIDTH-1:0]   fill_tag;
    logic [INDEX_WIDTH-1:0] fill_index;
    half_t                  fill_data;  // Words 0 to 3, or 4 to 7 with fill_last.
    logic                   fill_last;

    modport source (
        output fill_valid, fill_way, fill_tag, fill_index, fill_data, fill_last
    );

    modport sink (
        input fill_valid, fill_way, fill_tag, fill_index, fill_data, fill_last
    );

endinterface

// ==== common/refill_pkg.sv ====
// Shared refill types; the line is fixed at 64 bytes (two 256-bit beats, eight 64-bit words).
package refill_pkg;

    // Physical fetch address.
    typedef logic [31:0] pa_t;

    // One instruction word, the unit a fetch returns.
    typedef logic [63:0] word_t;

    // One bus beat carries half a line.
    typedef logic [255:0] beat_t;

    // Half a line as written by one fill strobe.
    typedef word_t half_t [4];

    typedef logic [1:0] way_t;

    // Word position in a line, address bits 5 to 3.
    typedef logic [2:0] word_sel_t;

    localparam int LINE_OFFSET_BITS = 6;
    localparam int NUM_WAYS = 4;

endpackage
